// ==== zmem_pkg.sv ====
/* zmem shared definitions
   paging ports, bank constants and DRAM request types */
package zmem_pkg;

	// paging ports, partially decoded
	// 7ffd needs a15=0 a1=0, dffd needs a15=1 a13=0 a1=0
	localparam logic [15:0] port_7ffd = 16'h7ffd;
	localparam logic [15:0] port_dffd = 16'hdffd;

	// ram page width and full DRAM byte address width
	localparam int unsigned page_bits = 8;
	localparam int unsigned addr_bits = page_bits + 14;

	// fixed banks behind 4000 and 8000
	localparam logic [page_bits-1:0] bank_4000 = 8'd5;
	localparam logic [page_bits-1:0] bank_8000 = 8'd2;

	// DRAM access length in fclk cycles, start cycle included
	localparam int unsigned seq_len = 5;

	// paging state, written by I/O and read by the mapper
	typedef struct packed {
		logic [page_bits-1:0] ram_page;
		logic                 rom_sel;
		logic                 lock;
	} page_state_t;

	// field view of a byte address
	// row 21:12, col 11:2, chip on bit 1, byte on bit 0
	// byte 0 is the upper half of the 16-bit word
	typedef struct packed {
		logic [9:0] row;
		logic [9:0] col;
		logic       chip;
		logic       byte_sel;
	} dram_fields_t;

	// mapper writes linear, sequencer reads fields
	typedef union packed {
		logic [addr_bits-1:0] linear;
		dram_fields_t         fields;
	} dram_addr_u;

	// one DRAM access request
	typedef struct packed {
		dram_addr_u addr;
		logic       we;
		logic [7:0] wdata;
	} dram_req_t;

	// ROM chip select lines
	typedef struct packed {
		logic csrom;
		logic romoe_n;
		logic rompg0_n;
	} rom_sel_t;

endpackage

// ==== zports.sv ====
/* paging ports 7ffd and dffd
   decodes Z80 I/O writes into ram page, rom select and lock */
`timescale 1ns/1ns

module zports
(
	input  logic                  fclk,
	input  logic                  rst_n,

	input  logic                  iorq_n,
	input  logic                  wr_n,
	input  logic                  m1_n,
	input  logic [15:0]           a,
	input  logic [7:0]            d,

	output zmem_pkg::page_state_t pages
);

	logic io_wr;
	logic io_wr_r;
	logic io_wr_stb;
	logic sel_7ffd;
	logic sel_dffd;

	// I/O write level, m1 low means intack, not a write
	assign io_wr = ~iorq_n & ~wr_n & m1_n;

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
			io_wr_r <= 1'b0;
		else
			io_wr_r <= io_wr;
	end

	// first cycle of the write only
	assign io_wr_stb = io_wr & ~io_wr_r;

	// partial decode, only a15 a13 a1 matter
	assign sel_7ffd = (a[15] == zmem_pkg::port_7ffd[15]) &&
	                  (a[1]  == zmem_pkg::port_7ffd[1]);

	assign sel_dffd = (a[15] == zmem_pkg::port_dffd[15]) &&
	                  (a[13] == zmem_pkg::port_dffd[13]) &&
	                  (a[1]  == zmem_pkg::port_dffd[1]);

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			pages.ram_page <= '0;
			pages.rom_sel  <= 1'b0;
			pages.lock     <= 1'b0;
		end
		else if (io_wr_stb && !pages.lock)
		begin
			// low page bits, rom half and lock
			if (sel_7ffd)
			begin
				pages.ram_page[2:0] <= d[2:0];
				pages.rom_sel       <= d[4];
				pages.lock          <= d[5];
			end
			// extended page bits
			if (sel_dffd)
				pages.ram_page[7:3] <= d[4:0];
		end
	end

endmodule

// ==== zmap.sv ====
/* Z80 memory mapper
   picks ROM or DRAM per 16K window and issues DRAM requests */
`timescale 1ns/1ns

module zmap
(
	input  logic                  fclk,
	input  logic                  rst_n,

	input  logic                  mreq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic [15:0]           a,
	input  logic [7:0]            d,

	input  zmem_pkg::page_state_t pages,

	output zmem_pkg::rom_sel_t    rom,
	output logic                  dram_start,
	output zmem_pkg::dram_req_t   dram_req
);

	logic                             mem_act;
	logic                             mem_act_r;
	logic                             mem_stb;
	logic                             is_rom;
	logic [zmem_pkg::page_bits-1:0]   page;

	// memory cycle is live once a strobe joins mreq
	assign mem_act = ~mreq_n & (~rd_n | ~wr_n);
	assign mem_stb = mem_act & ~mem_act_r;

	// 0000..3fff is ROM
	assign is_rom = (a[15:14] == 2'b00);

	// bank for the current window
	always_comb
	begin
		case (a[15:14])
			2'b01:   page = zmem_pkg::bank_4000;
			2'b10:   page = zmem_pkg::bank_8000;
			default: page = pages.ram_page;
		endcase
	end

	// ROM lines follow the bus directly
	assign rom.csrom    = is_rom & ~mreq_n;
	assign rom.romoe_n  = ~(is_rom & ~mreq_n & ~rd_n);
	assign rom.rompg0_n = ~pages.rom_sel;

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			mem_act_r  <= 1'b0;
			dram_start <= 1'b0;
		end
		else
		begin
			mem_act_r  <= mem_act;
			// ROM writes just vanish here
			dram_start <= mem_stb & ~is_rom;
		end
	end

	// request payload, captured with the start pulse
	always_ff @(posedge fclk)
	begin
		if (mem_stb)
		begin
			dram_req.addr.linear <= {page, a[13:0]};
			dram_req.we          <= ~wr_n;
			dram_req.wdata       <= d;
		end
	end

endmodule

// ==== dram_seq.sv ====
/* DRAM access sequencer for two 16-bit chips
   fixed row, column, CAS and capture steps per request */
`timescale 1ns/1ns

module dram_seq
(
	input  logic                fclk,
	input  logic                rst_n,

	input  logic                dram_start,
	input  zmem_pkg::dram_req_t dram_req,

	input  logic [15:0]         rd_in,

	output logic [9:0]          ra,
	output logic [15:0]         rd_out,
	output logic                rd_oe,
	output logic                rwe_n,
	output logic                rucas_n,
	output logic                rlcas_n,
	output logic                rras0_n,
	output logic                rras1_n,

	output logic [7:0]          rdata,
	output logic                rdata_valid
);

	// last step of the access, RAS precharge
	localparam logic [2:0] last_ph = 3'(zmem_pkg::seq_len - 1);

	logic [2:0]          phase;
	logic [2:0]          phase_nxt;
	logic                busy;
	logic                ras_nxt;
	logic                cas_nxt;
	zmem_pkg::dram_req_t req;
	zmem_pkg::dram_req_t cur;

	// phase 0 idle, 1 row, 2..3 col, 4 precharge
	assign busy = (phase != 3'd0);

	always_comb
	begin
		if (!busy)
			phase_nxt = dram_start ? 3'd1 : 3'd0;
		else if (phase == last_ph)
			phase_nxt = 3'd0;
		else
			phase_nxt = phase + 3'd1;
	end

	// new request not latched yet on the first step
	assign cur = busy ? req : dram_req;

	assign ras_nxt = (phase_nxt >= 3'd1) && (phase_nxt <= 3'd3);
	assign cas_nxt = (phase_nxt == 3'd2) || (phase_nxt == 3'd3);

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
			phase <= 3'd0;
		else
			phase <= phase_nxt;
	end

	// hold the request for the whole access
	// a start while busy is dropped
	always_ff @(posedge fclk)
	begin
		if (!busy && dram_start)
			req <= dram_req;
	end

	// strobes, registered so the pins stay clean
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			rras0_n <= 1'b1;
			rras1_n <= 1'b1;
			rucas_n <= 1'b1;
			rlcas_n <= 1'b1;
			rwe_n   <= 1'b1;
			rd_oe   <= 1'b0;
		end
		else
		begin
			// chip bit picks the RAS
			rras0_n <= ~(ras_nxt & ~cur.addr.fields.chip);
			rras1_n <= ~(ras_nxt &  cur.addr.fields.chip);
			// byte 0 on upper CAS, byte 1 on lower
			rucas_n <= ~(cas_nxt & ~cur.addr.fields.byte_sel);
			rlcas_n <= ~(cas_nxt &  cur.addr.fields.byte_sel);
			// write enable and bus drive together
			rwe_n   <= ~(cas_nxt & cur.we);
			rd_oe   <= cas_nxt & cur.we;
		end
	end

	// multiplexed address and write data
	always_ff @(posedge fclk)
	begin
		if (phase_nxt == 3'd1)
			ra <= cur.addr.fields.row;
		else
			ra <= cur.addr.fields.col;

		// same byte on both halves, CAS picks the lane
		rd_out <= {cur.wdata, cur.wdata};
	end

	// read capture at end of last CAS step
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
			rdata_valid <= 1'b0;
		else
			rdata_valid <= (phase == 3'd3) && !req.we;
	end

	always_ff @(posedge fclk)
	begin
		if ((phase == 3'd3) && !req.we)
			rdata <= req.addr.fields.byte_sel ? rd_in[7:0] : rd_in[15:8];
	end

endmodule

// ==== zmem_top.sv ====
/* memory side top level
   paging ports, mapper and DRAM sequencer on the board pins */
`timescale 1ns/1ns

module zmem_top
(
	input  logic        fclk,
	input  logic        rst_n,

	// Z80 bus
	input  logic        mreq_n,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        m1_n,
	input  logic [15:0] a,
	input  logic [7:0]  d,

	output logic [7:0]  dout,
	output logic        dout_ena,

	// ROM
	output logic        csrom,
	output logic        romoe_n,
	output logic        rompg0_n,

	// DRAM
	input  logic [15:0] rd_in,
	output logic [9:0]  ra,
	output logic [15:0] rd_out,
	output logic        rd_oe,
	output logic        rwe_n,
	output logic        rucas_n,
	output logic        rlcas_n,
	output logic        rras0_n,
	output logic        rras1_n
);

	zmem_pkg::page_state_t pages;
	zmem_pkg::rom_sel_t    rom;
	zmem_pkg::dram_req_t   dram_req;
	logic                  dram_start;
	logic [7:0]            rdata;
	logic                  rdata_valid;
	logic [7:0]            rd_byte;
	logic                  ena_hold;

	zports u_zports
	(
		.fclk   (fclk),
		.rst_n  (rst_n),
		.iorq_n (iorq_n),
		.wr_n   (wr_n),
		.m1_n   (m1_n),
		.a      (a),
		.d      (d),
		.pages  (pages)
	);

	zmap u_zmap
	(
		.fclk       (fclk),
		.rst_n      (rst_n),
		.mreq_n     (mreq_n),
		.rd_n       (rd_n),
		.wr_n       (wr_n),
		.a          (a),
		.d          (d),
		.pages      (pages),
		.rom        (rom),
		.dram_start (dram_start),
		.dram_req   (dram_req)
	);

	dram_seq u_dram_seq
	(
		.fclk        (fclk),
		.rst_n       (rst_n),
		.dram_start  (dram_start),
		.dram_req    (dram_req),
		.rd_in       (rd_in),
		.ra          (ra),
		.rd_out      (rd_out),
		.rd_oe       (rd_oe),
		.rwe_n       (rwe_n),
		.rucas_n     (rucas_n),
		.rlcas_n     (rlcas_n),
		.rras0_n     (rras0_n),
		.rras1_n     (rras1_n),
		.rdata       (rdata),
		.rdata_valid (rdata_valid)
	);

	assign csrom    = rom.csrom;
	assign romoe_n  = rom.romoe_n;
	assign rompg0_n = rom.rompg0_n;

	// keep the read byte until the CPU ends the cycle
	always_ff @(posedge fclk)
	begin
		if (rdata_valid)
			rd_byte <= rdata;
	end

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
			ena_hold <= 1'b0;
		else if (rdata_valid)
			ena_hold <= 1'b1;
		else if (mreq_n)
			ena_hold <= 1'b0;
	end

	// data goes out in the same cycle as the capture
	assign dout     = rdata_valid ? rdata : rd_byte;
	assign dout_ena = rdata_valid | ena_hold;

endmodule

// ==== dram_model.sv ====
/* behavioural 16-bit DRAM chip
   row latched on RAS fall, byte lanes written under upper and lower CAS */
`timescale 1ns/1ns

module dram_model
(
	input  logic        fclk,
	input  logic        ras_n,
	input  logic        ucas_n,
	input  logic        lcas_n,
	input  logic        we_n,
	input  logic [9:0]  ra,
	input  logic [15:0] wd,
	output logic [15:0] q
);

	// 1M words, row then column
	logic [15:0] mem [0:1048575];
	logic [9:0]  row;
	logic        ras_q;

	always @(posedge fclk)
	begin
		ras_q <= ras_n;
		if (!ras_n && ras_q)
			row <= ra;
		// upper lane is byte 0
		if (!ras_n && !we_n && !ucas_n)
			mem[{row, ra}][15:8] <= wd[15:8];
		if (!ras_n && !we_n && !lcas_n)
			mem[{row, ra}][7:0] <= wd[7:0];
	end

	// read word for the open row and current column
	assign q = mem[{row, ra}];

endmodule

// ==== zmem_assertions.sv ====
/* DRAM strobe assertions bound into dram_seq
   one RAS at a time, CAS under RAS, rwe_n with rd_oe, no start while busy */
`timescale 1ns/1ns

module zmem_assertions
(
	input logic fclk,
	input logic rst_n,
	input logic dram_start,
	input logic busy,
	input logic rd_oe,
	input logic rwe_n,
	input logic rucas_n,
	input logic rlcas_n,
	input logic rras0_n,
	input logic rras1_n
);

	// one chip per access
	one_ras: assert property (@(posedge fclk) disable iff (!rst_n)
		!(!rras0_n && !rras1_n))
		else $error("both RAS strobes low together");

	cas_under_ras: assert property (@(posedge fclk) disable iff (!rst_n)
		(!rucas_n || !rlcas_n) |-> (!rras0_n || !rras1_n))
		else $error("CAS low with both RAS high");

	// write enable only while the bus is driven
	we_with_oe: assert property (@(posedge fclk) disable iff (!rst_n)
		!rwe_n |-> rd_oe)
		else $error("rwe_n low without rd_oe");

	start_when_idle: assert property (@(posedge fclk) disable iff (!rst_n)
		dram_start |-> !busy)
		else $error("dram_start while the sequencer is busy");

endmodule

bind dram_seq zmem_assertions u_zmem_assertions
(
	.fclk       (fclk),
	.rst_n      (rst_n),
	.dram_start (dram_start),
	.busy       (busy),
	.rd_oe      (rd_oe),
	.rwe_n      (rwe_n),
	.rucas_n    (rucas_n),
	.rlcas_n    (rlcas_n),
	.rras0_n    (rras0_n),
	.rras1_n    (rras1_n)
);

// ==== zmem_checker.sv ====
/* zmem checker
   tracks paging from the bus, checks DRAM lanes, ROM lines and read data */
`timescale 1ns/1ns

module zmem_checker
(
	input  logic        fclk,
	input  logic        rst_n,
	input  logic        mreq_n,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        m1_n,
	input  logic [15:0] a,
	input  logic [7:0]  d,
	input  logic [7:0]  dout,
	input  logic        dout_ena,
	input  logic        csrom,
	input  logic        romoe_n,
	input  logic        rompg0_n,
	input  logic [9:0]  ra,
	input  logic        rd_oe,
	input  logic        rwe_n,
	input  logic        rucas_n,
	input  logic        rlcas_n,
	input  logic        rras0_n,
	input  logic        rras1_n,
	input  logic [7:0]  exp_byte,
	input  logic        entry_done,
	input  int          entry_idx,
	output int          n_ok,
	output int          n_bad
);

	zmem_pkg::page_state_t          pg;
	zmem_pkg::dram_addr_u           want;
	logic [zmem_pkg::page_bits-1:0] page;
	logic                           io_q;
	logic                           mem_q;
	logic                           ras_q;
	logic                           cas_q;
	logic                           ena_q;
	logic                           rst_q;
	logic                           act;
	logic                           is_rom;
	logic                           is_wr;
	logic                           is_rd;
	int                             errs;

	task automatic mismatch(input string msg);
		$display("[ERROR] %0t ns: %s", $time, msg);
		errs++;
	endtask

	always @(posedge fclk)
	begin
		if (!rst_n)
		begin
			pg     = '0;
			want   = '0;
			io_q   = 1'b0;
			mem_q  = 1'b0;
			ras_q  = 1'b1;
			cas_q  = 1'b1;
			ena_q  = 1'b0;
			rst_q  = 1'b0;
			act    = 1'b0;
			is_rom = 1'b0;
			is_wr  = 1'b0;
			is_rd  = 1'b0;
			errs   = 0;
			n_ok   = 0;
			n_bad  = 0;
		end
		else
		begin
			// idle pins on the first clock out of reset
			if (!rst_q)
			begin
				if (!rras0_n || !rras1_n || !rucas_n || !rlcas_n || !rwe_n)
					mismatch("DRAM strobe low after reset");
				if (rd_oe || dout_ena || csrom || !romoe_n)
					mismatch("rd_oe, dout_ena or ROM select active after reset");
			end

			// paging ports, first cycle of an I/O write, partial decode
			if (!iorq_n && !wr_n && m1_n && !io_q && !pg.lock)
			begin
				if (!a[15] && !a[1])
				begin
					pg.ram_page[2:0] = d[2:0];
					pg.rom_sel       = d[4];
					pg.lock          = d[5];
				end
				if (a[15] && !a[13] && !a[1])
					pg.ram_page[7:3] = d[4:0];
			end

			// new memory cycle, expected byte address from the window
			if (!mreq_n && (!rd_n || !wr_n) && !mem_q)
			begin
				case (a[15:14])
					2'b01:   page = zmem_pkg::bank_4000;
					2'b10:   page = zmem_pkg::bank_8000;
					default: page = pg.ram_page;
				endcase
				want.linear = {page, a[13:0]};
				is_rom      = (a[15:14] == 2'b00);
				is_wr       = !wr_n;
				is_rd       = !rd_n;
				act         = 1'b1;
			end
			if (mreq_n)
				act = 1'b0;

			// ROM cycle, DRAM stays quiet
			if (act && is_rom)
			begin
				if (!rras0_n || !rras1_n || !rucas_n || !rlcas_n || !rwe_n)
					mismatch("DRAM strobe moved during a ROM cycle");
				if (!csrom)
					mismatch("csrom low during a ROM cycle");
				if (is_rd && romoe_n)
					mismatch("romoe_n high during a ROM read");
				if (rompg0_n == pg.rom_sel)
					mismatch($sformatf("rompg0_n %0b with rom_sel %0b", rompg0_n, pg.rom_sel));
			end

			// RAS fall carries the row
			if ((!rras0_n || !rras1_n) && ras_q)
			begin
				if (rras0_n != want.fields.chip || rras1_n == want.fields.chip)
					mismatch($sformatf("wrong RAS for chip %0d", want.fields.chip));
				if (ra != want.fields.row)
					mismatch($sformatf("row %h, expected %h", ra, want.fields.row));
			end

			// CAS fall carries the column and byte lane
			if ((!rucas_n || !rlcas_n) && cas_q)
			begin
				if (rucas_n != want.fields.byte_sel || rlcas_n == want.fields.byte_sel)
					mismatch($sformatf("wrong CAS for byte %0d", want.fields.byte_sel));
				if (ra != want.fields.col)
					mismatch($sformatf("col %h, expected %h", ra, want.fields.col));
				if (rwe_n == is_wr)
					mismatch("rwe_n does not match the cycle direction");
			end

			if (dout_ena && !ena_q && act && is_rd && !is_rom)
			begin
				if (dout != exp_byte)
					mismatch($sformatf("dout %h, expected %h", dout, exp_byte));
			end

			// close the entry
			if (entry_done)
			begin
				if (errs == 0)
				begin
					n_ok++;
					$display("entry %0d a=%h ok", entry_idx, a);
				end
				else
				begin
					n_bad++;
					$display("entry %0d a=%h failed, %0d errors", entry_idx, a, errs);
				end
				errs = 0;
			end

			io_q  = !iorq_n && !wr_n && m1_n;
			mem_q = !mreq_n && (!rd_n || !wr_n);
			ras_q = rras0_n && rras1_n;
			cas_q = rucas_n && rlcas_n;
			ena_q = dout_ena;
			rst_q = 1'b1;
		end
	end

endmodule

// ==== tb_zmem.sv ====
/* zmem testbench top
   table of Z80 bus cycles against two DRAM chip models */
`timescale 1ns/1ns

module tb_zmem;

	// bus cycle kinds in the table
	typedef enum logic [1:0]
	{
		io_wr,
		mem_wr,
		mem_rd
	} kind_t;

	typedef struct packed {
		kind_t       kind;
		logic [15:0] a;
		logic [7:0]  d;
		logic [7:0]  want;
	} entry_t;

	logic        fclk;
	logic        rst_n;
	logic        mreq_n;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic        m1_n;
	logic [15:0] a;
	logic [7:0]  d;
	logic [7:0]  dout;
	logic        dout_ena;
	logic        csrom;
	logic        romoe_n;
	logic        rompg0_n;
	logic [15:0] rd_in;
	logic [9:0]  ra;
	logic [15:0] rd_out;
	logic        rd_oe;
	logic        rwe_n;
	logic        rucas_n;
	logic        rlcas_n;
	logic        rras0_n;
	logic        rras1_n;
	logic [15:0] q0;
	logic [15:0] q1;

	// checker side
	logic [7:0]  exp_byte;
	logic        entry_done;
	int          entry_idx;
	int          n_ok;
	int          n_bad;

	entry_t      tbl [$];
	logic [31:0] seed;
	logic        stuck;
	string       stuck_why;

	zmem_top dut (.*);

	zmem_checker u_checker (.*);

	dram_model u_chip0
	(
		.fclk   (fclk),
		.ras_n  (rras0_n),
		.ucas_n (rucas_n),
		.lcas_n (rlcas_n),
		.we_n   (rwe_n),
		.ra     (ra),
		.wd     (rd_out),
		.q      (q0)
	);

	dram_model u_chip1
	(
		.fclk   (fclk),
		.ras_n  (rras1_n),
		.ucas_n (rucas_n),
		.lcas_n (rlcas_n),
		.we_n   (rwe_n),
		.ra     (ra),
		.wd     (rd_out),
		.q      (q1)
	);

	// chip 1 owns the bus while its RAS is low
	assign rd_in = !rras1_n ? q1 : q0;

	initial
	begin
		fclk = 1'b0;
		forever #5 fclk = ~fclk;
	end

	// LCG step with the data byte taken from the middle bits
	function automatic logic [7:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[23:16];
	endfunction

	task automatic push_entry(input kind_t k, input logic [15:0] addr,
	                          input logic [7:0] data, input logic [7:0] w);
		entry_t e;
		e.kind = k;
		e.a    = addr;
		e.d    = data;
		e.want = w;
		tbl.push_back(e);
	endtask

	// wait target 0 is a RAS low
	// 1 is both RAS high and 2 is dout_ena
	function automatic logic pin_state(input int what);
		case (what)
			0:       return !rras0_n || !rras1_n;
			1:       return rras0_n && rras1_n;
			default: return dout_ena;
		endcase
	endfunction

	task automatic wait_pins(input int what, input string why);
		int n;
		n = 0;
		while (!stuck && !pin_state(what))
		begin
			if (n == 20)
			begin
				stuck     = 1'b1;
				stuck_why = why;
			end
			else
			begin
				@(negedge fclk);
				n++;
			end
		end
	endtask

	task automatic build_table();
		logic [7:0] b1;
		logic [7:0] b2;
		logic [7:0] b3;
		logic [7:0] b4;
		logic [7:0] p1;
		logic [7:0] p2;
		logic [7:0] lane [4];
		// ROM read straight after reset with rom_sel still clear
		push_entry(mem_rd, 16'h0000, 8'h00, 8'h00);
		// fixed banks on page 5 and page 2
		b1 = next_rand();
		b2 = next_rand();
		push_entry(mem_wr, 16'h4a31, b1, 8'h00);
		push_entry(mem_rd, 16'h4a31, 8'h00, b1);
		push_entry(mem_wr, 16'hb1c6, b2, 8'h00);
		push_entry(mem_rd, 16'hb1c6, 8'h00, b2);
		// two random pages at one C000 offset
		p1 = next_rand();
		p2 = p1 ^ 8'h5a;
		b3 = next_rand();
		b4 = next_rand();
		push_entry(io_wr, 16'h7ffd, {5'd0, p1[2:0]}, 8'h00);
		push_entry(io_wr, 16'hdffd, {3'd0, p1[7:3]}, 8'h00);
		push_entry(mem_wr, 16'hd2e7, b3, 8'h00);
		push_entry(io_wr, 16'h7ffd, {5'd0, p2[2:0]}, 8'h00);
		push_entry(io_wr, 16'hdffd, {3'd0, p2[7:3]}, 8'h00);
		push_entry(mem_wr, 16'hd2e7, b4, 8'h00);
		push_entry(mem_rd, 16'hd2e7, 8'h00, b4);
		push_entry(io_wr, 16'h7ffd, {5'd0, p1[2:0]}, 8'h00);
		push_entry(io_wr, 16'hdffd, {3'd0, p1[7:3]}, 8'h00);
		push_entry(mem_rd, 16'hd2e7, 8'h00, b3);
		// second ROM half then a ROM write that must go nowhere
		push_entry(io_wr, 16'h7ffd, 8'h10 | {5'd0, p1[2:0]}, 8'h00);
		push_entry(mem_rd, 16'h0100, 8'h00, 8'h00);
		push_entry(mem_wr, 16'h2345, next_rand(), 8'h00);
		// lock on p1 so the later p2 writes are dropped
		push_entry(io_wr, 16'h7ffd, 8'h30 | {5'd0, p1[2:0]}, 8'h00);
		push_entry(io_wr, 16'h7ffd, {5'd0, p2[2:0]}, 8'h00);
		push_entry(io_wr, 16'hdffd, {3'd0, p2[7:3]}, 8'h00);
		push_entry(mem_rd, 16'hd2e7, 8'h00, b3);
		// 8104..8107 walk both chips and both byte lanes
		for (int k = 0; k < 4; k++)
		begin
			lane[k] = next_rand();
			push_entry(mem_wr, {14'h2041, 2'(k)}, lane[k], 8'h00);
		end
		for (int k = 0; k < 4; k++)
			push_entry(mem_rd, {14'h2041, 2'(k)}, 8'h00, lane[k]);
	endtask

	// one bus cycle with the strobes changed on the falling edge
	task automatic run_entry(input entry_t e);
		logic is_rom;
		is_rom   = (e.a[15:14] == 2'b00);
		a        = e.a;
		d        = e.d;
		exp_byte = e.want;
		case (e.kind)
			io_wr:
			begin
				iorq_n = 1'b0;
				wr_n   = 1'b0;
				repeat (3) @(negedge fclk);
			end
			mem_wr:
			begin
				mreq_n = 1'b0;
				wr_n   = 1'b0;
				if (is_rom)
					repeat (6) @(negedge fclk);
				else
				begin
					wait_pins(0, "RAS to fall on a write");
					wait_pins(1, "RAS to return high after a write");
				end
			end
			default:
			begin
				mreq_n = 1'b0;
				rd_n   = 1'b0;
				if (is_rom)
					repeat (6) @(negedge fclk);
				else
				begin
					wait_pins(2, "dout_ena on a read");
					@(negedge fclk);
				end
			end
		endcase
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		repeat (2) @(negedge fclk);
	endtask

	initial
	begin
		rst_n      = 1'b0;
		mreq_n     = 1'b1;
		iorq_n     = 1'b1;
		rd_n       = 1'b1;
		wr_n       = 1'b1;
		m1_n       = 1'b1;
		a          = 16'h0000;
		d          = 8'h00;
		exp_byte   = 8'h00;
		entry_done = 1'b0;
		entry_idx  = 0;
		stuck      = 1'b0;
		stuck_why  = "";
		seed       = 32'ha867_14c1;
		build_table();

		repeat (5) @(negedge fclk);
		rst_n = 1'b1;
		@(negedge fclk);

		for (int i = 0; i < tbl.size(); i++)
		begin
			run_entry(tbl[i]);
			if (stuck)
				break;
			// let the checker close this entry
			entry_idx  = i;
			entry_done = 1'b1;
			@(negedge fclk);
			entry_done = 1'b0;
		end

		if (stuck)
			$display("run stopped, no response while waiting for %s", stuck_why);
		$display("entries %0d, ok %0d, failed %0d", tbl.size(), n_ok, n_bad);
		if (!stuck && n_bad == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== vlog.f ====
zmem_pkg.sv
zports.sv
zmap.sv
dram_seq.sv
zmem_top.sv
dram_model.sv
zmem_assertions.sv
zmem_checker.sv
tb_zmem.sv

// ==== run.sh ====
#!/bin/sh
# build the zmem testbench with Verilator, run it, check the log
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tb_zmem -f vlog.f > build.log 2>&1 &&
obj_dir/Vtb_zmem | tee sim.log
grep -q '^>>> PASS$' sim.log 2>/dev/null && echo "simulation passed" ||
	{ echo "simulation failed, see build.log and sim.log"; exit 1; }
